//--- include/alu_cfg.svh
// data width, register count, axi address width and register offsets for the coprocessor
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// width of one datapath word
`define DATA_W 16

// number of general purpose registers
`define REG_COUNT 8

// byte address width of the axi4-lite slave
`define AXI_ADDR_W 6

// instruction issue word, write issues and read returns last word
`define ADDR_INSTR 6'h00
// flags in the low bits, executed count in the high half
`define ADDR_STATUS 6'h04
// first register of the read-only window, one word per register
`define ADDR_REGBASE 6'h20

`endif

//--- hw/aluPkg.sv
// data word, register index, flag vector and opcode types shared by the coprocessor
`include "alu_cfg.svh"

package aluPkg;

    // one datapath word
    typedef logic [`DATA_W-1:0] word_t;

    // register number, sized from the register count
    typedef logic [$clog2(`REG_COUNT)-1:0] regIdx_t;

    // condition codes
    // bit 0 zero, bit 1 negative, bit 2 carry
    typedef logic [2:0] ccr_t;

    // operation codes in instruction encoding order
    // codes above LDM are not listed and decode as NOP
    typedef enum logic [3:0] {
        NOP = 4'd0,
        ADD = 4'd1,
        NOT = 4'd2,
        INC = 4'd3,
        DEC = 4'd4,
        SUB = 4'd5,
        AND = 4'd6,
        OR  = 4'd7,
        SHL = 4'd8,
        SHR = 4'd9,
        IN  = 4'd10,
        LDM = 4'd11
    } aluOp_e;

endpackage

//--- hw/alu.sv
// combinational alu computing the result word and the condition flags of one operation
`timescale 1ns/1ns
`include "alu_cfg.svh"

module alu import aluPkg::*; (
    input  aluOp_e op,
    // source and destination register values
    input  word_t  src,
    input  word_t  dst,
    // immediate field of the instruction, used by LDM
    input  word_t  imm,
    // external input port, used by IN
    input  word_t  inPort,
    output word_t  result,
    output ccr_t   flags
);

    // 17 bit sum so the carry out of ADD is visible
    logic [`DATA_W:0] sum;

    assign sum = {1'b0, src} + {1'b0, dst};

    // result select
    always_comb begin
        case (op)
            ADD: begin
                result = sum[`DATA_W-1:0];
            end
            NOT: begin
                result = ~dst;
            end
            INC: begin
                result = dst + word_t'(1);
            end
            DEC: begin
                result = dst - word_t'(1);
            end
            SUB: begin
                // destination minus source
                result = dst - src;
            end
            AND: begin
                result = src & dst;
            end
            OR: begin
                result = src | dst;
            end
            SHL: begin
                // shift count is the full source word, 16 or more clears
                result = dst << src;
            end
            SHR: begin
                // logical, zero fill from the top
                result = dst >> src;
            end
            IN: begin
                result = inPort;
            end
            LDM: begin
                result = imm;
            end
            default: begin
                // nop leaves dst on the bus, nothing is written back
                result = dst;
            end
        endcase
    end

    // zero flag
    assign flags[0] = (result == '0);

    // negative flag from the sign bit
    assign flags[1] = result[`DATA_W-1];

    // carry only from ADD, cleared for everything else
    assign flags[2] = (op == ADD) ? sum[`DATA_W] : 1'b0;

endmodule

//--- hw/regFile.sv
// register file with two core read ports, one host read port and one write port
`timescale 1ns/1ns
`include "alu_cfg.svh"

module regFile import aluPkg::*; (
    input  logic    clk,
    input  logic    reset,
    // core read ports
    input  regIdx_t srcIdx,
    input  regIdx_t dstIdx,
    output word_t   srcVal,
    output word_t   dstVal,
    // host read port for the register window
    input  regIdx_t hostIdx,
    output word_t   hostVal,
    // writeback port from the core
    input  logic    wrEn,
    input  regIdx_t wrIdx,
    input  word_t   wrData
);

    // register storage
    word_t regs [`REG_COUNT];

    // synchronous write, all registers cleared on reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrIdx] <= wrData;
        end
    end

    // combinational reads
    // a read of the register being written sees the old value
    assign srcVal = regs[srcIdx];
    assign dstVal = regs[dstIdx];

    // host port is independent of the core ports
    assign hostVal = regs[hostIdx];

endmodule

//--- hw/execCore.sv
// instruction decode, alu drive, writeback, flag register and executed-instruction count
`timescale 1ns/1ns

module execCore import aluPkg::*; (
    input  logic        clk,
    input  logic        reset,
    // one cycle issue pulse with the instruction word
    input  logic        issue,
    input  logic [31:0] instr,
    input  word_t       inPort,
    // register file read
    output regIdx_t     srcIdx,
    output regIdx_t     dstIdx,
    input  word_t       srcVal,
    input  word_t       dstVal,
    // register file write
    output logic        wrEn,
    output regIdx_t     wrIdx,
    output word_t       wrData,
    // status to the host block
    output ccr_t        ccr,
    output logic [15:0] execCount
);

    // instruction fields
    word_t       imm;
    logic [3:0]  opcode;
    aluOp_e      op;
    word_t       aluResult;
    ccr_t        aluFlags;
    logic        doExec;

    // layout is imm, opcode, dst, src, low six bits unused
    assign imm    = instr[31:16];
    assign opcode = instr[15:12];
    assign dstIdx = instr[11:9];
    assign srcIdx = instr[8:6];

    // codes past LDM fold into NOP
    always_comb begin
        if (opcode <= 4'(LDM)) begin
            op = aluOp_e'(opcode);
        end else begin
            op = NOP;
        end
    end

    alu aluInst (
        .op     (op),
        .src    (srcVal),
        .dst    (dstVal),
        .imm    (imm),
        .inPort (inPort),
        .result (aluResult),
        .flags  (aluFlags)
    );

    // only real operations have any effect
    assign doExec = issue && (op != NOP);

    // writeback at the closing edge of the issue cycle
    assign wrEn   = doExec;
    assign wrIdx  = dstIdx;
    assign wrData = aluResult;

    // flags and count move together with the write
    always_ff @(posedge clk) begin
        if (reset) begin
            ccr       <= '0;
            execCount <= '0;
        end else if (doExec) begin
            ccr       <= aluFlags;
            // wraps at 16 bits
            execCount <= execCount + 16'd1;
        end
    end

endmodule

//--- hw/hostRegs.sv
// axi4-lite slave with instruction issue, status read and register read window
`timescale 1ns/1ns
`include "alu_cfg.svh"

module hostRegs import aluPkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    // write address
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [`AXI_ADDR_W-1:0] awaddr,
    // write data, full words only
    input  logic                   wvalid,
    output logic                   wready,
    input  logic [31:0]            wdata,
    // write response
    output logic                   bvalid,
    input  logic                   bready,
    output logic [1:0]             bresp,
    // read address
    input  logic                   arvalid,
    output logic                   arready,
    input  logic [`AXI_ADDR_W-1:0] araddr,
    // read data
    output logic                   rvalid,
    input  logic                   rready,
    output logic [31:0]            rdata,
    output logic [1:0]             rresp,
    // issue to the core
    output logic                   issue,
    output logic [31:0]            instr,
    // status from the core
    input  ccr_t                   ccr,
    input  logic [15:0]            execCount,
    // register window port
    output regIdx_t                hostIdx,
    input  word_t                  hostVal
);

    // axi response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // write channel state, idle or response pending
    typedef enum logic {
        W_IDLE,
        W_RESP
    } wrState_e;

    wrState_e    wrState;
    logic        wrAccept;
    logic        wrInstrHit;
    logic        rdAccept;
    logic        rdRegHit;
    logic [31:0] lastInstr;
    logic [31:0] rdWord;
    logic [1:0]  rdResp;

    // write side

    // aw and w accepted together, blocked while a response is pending
    assign wrAccept = awvalid && wvalid && (wrState == W_IDLE);
    assign awready  = wrAccept;
    assign wready   = wrAccept;

    // only the instruction word is writable
    assign wrInstrHit = (awaddr == `ADDR_INSTR);

    // issue in the accept cycle so the core writes back on the bvalid edge
    assign issue = wrAccept && wrInstrHit;
    assign instr = wdata;

    assign bvalid = (wrState == W_RESP);

    always_ff @(posedge clk) begin
        if (reset) begin
            wrState   <= W_IDLE;
            bresp     <= RESP_OKAY;
            lastInstr <= '0;
        end else begin
            case (wrState)
                W_IDLE: begin
                    if (wrAccept) begin
                        wrState <= W_RESP;
                        // status and register window are read-only
                        bresp   <= wrInstrHit ? RESP_OKAY : RESP_SLVERR;
                        if (wrInstrHit) begin
                            lastInstr <= wdata;
                        end
                    end
                end
                W_RESP: begin
                    if (bready) begin
                        wrState <= W_IDLE;
                    end
                end
                default: begin
                    wrState <= W_IDLE;
                end
            endcase
        end
    end

    // read side

    // one read outstanding at a time
    assign rdAccept = arvalid && !rvalid;
    assign arready  = rdAccept;

    // window covers 0x20 to 0x3c, word aligned
    assign rdRegHit = (araddr >= `ADDR_REGBASE) && (araddr[1:0] == 2'b00);
    assign hostIdx  = araddr[4:2];

    // read mux
    always_comb begin
        rdWord = '0;
        rdResp = RESP_OKAY;
        if (araddr == `ADDR_INSTR) begin
            rdWord = lastInstr;
        end else if (araddr == `ADDR_STATUS) begin
            // count in the upper half, flags in the low three bits
            rdWord = {execCount, 13'd0, ccr};
        end else if (rdRegHit) begin
            rdWord = {{(32-`DATA_W){1'b0}}, hostVal};
        end else begin
            rdResp = RESP_SLVERR;
        end
    end

    // data captured at accept and held until rready
    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid <= 1'b0;
            rdata  <= '0;
            rresp  <= RESP_OKAY;
        end else if (rdAccept) begin
            rvalid <= 1'b1;
            rdata  <= rdWord;
            rresp  <= rdResp;
        end else if (rvalid && rready) begin
            rvalid <= 1'b0;
        end
    end

endmodule

//--- hw/aluCoprocTop.sv
// coprocessor top level joining the axi slave, execution core and register file
`timescale 1ns/1ns
`include "alu_cfg.svh"

module aluCoprocTop import aluPkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  word_t                  inPort,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [`AXI_ADDR_W-1:0] awaddr,
    input  logic                   wvalid,
    output logic                   wready,
    input  logic [31:0]            wdata,
    output logic                   bvalid,
    input  logic                   bready,
    output logic [1:0]             bresp,
    input  logic                   arvalid,
    output logic                   arready,
    input  logic [`AXI_ADDR_W-1:0] araddr,
    output logic                   rvalid,
    input  logic                   rready,
    output logic [31:0]            rdata,
    output logic [1:0]             rresp
);

    // host to core
    logic        issue;
    logic [31:0] instr;
    // core to host
    ccr_t        ccr;
    logic [15:0] execCount;
    // register file ports
    regIdx_t     srcIdx;
    regIdx_t     dstIdx;
    regIdx_t     hostIdx;
    regIdx_t     wrIdx;
    word_t       srcVal;
    word_t       dstVal;
    word_t       hostVal;
    word_t       wrData;
    logic        wrEn;

    hostRegs hostRegsInst (
        .clk       (clk),
        .reset     (reset),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata     (wdata),
        .bvalid    (bvalid),
        .bready    (bready),
        .bresp     (bresp),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata     (rdata),
        .rresp     (rresp),
        .issue     (issue),
        .instr     (instr),
        .ccr       (ccr),
        .execCount (execCount),
        .hostIdx   (hostIdx),
        .hostVal   (hostVal)
    );

    execCore execCoreInst (
        .clk       (clk),
        .reset     (reset),
        .issue     (issue),
        .instr     (instr),
        .inPort    (inPort),
        .srcIdx    (srcIdx),
        .dstIdx    (dstIdx),
        .srcVal    (srcVal),
        .dstVal    (dstVal),
        .wrEn      (wrEn),
        .wrIdx     (wrIdx),
        .wrData    (wrData),
        .ccr       (ccr),
        .execCount (execCount)
    );

    regFile regFileInst (
        .clk     (clk),
        .reset   (reset),
        .srcIdx  (srcIdx),
        .dstIdx  (dstIdx),
        .srcVal  (srcVal),
        .dstVal  (dstVal),
        .hostIdx (hostIdx),
        .hostVal (hostVal),
        .wrEn    (wrEn),
        .wrIdx   (wrIdx),
        .wrData  (wrData)
    );

endmodule

//--- testbench/aluCoproc_assert.sv
// concurrent axi4-lite handshake, issue pulse and reset assertions bound into the coprocessor top
`timescale 1ns/1ns

module aluCoprocAssert (
    input logic        clk,
    input logic        reset,
    input logic        awready,
    input logic        wready,
    input logic        arready,
    input logic        bvalid,
    input logic        bready,
    input logic [1:0]  bresp,
    input logic        rvalid,
    input logic        rready,
    input logic [31:0] rdata,
    input logic [1:0]  rresp,
    input logic        issue
);

    // write response waits for the host
    bHoldChk: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("bvalid dropped or bresp changed before bready");

    // read data frozen until taken
    rHoldChk: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else $error("rvalid dropped or read response changed before rready");

    // single cycle issue
    issuePulseChk: assert property (@(posedge clk) disable iff (reset)
        issue |=> !issue)
        else $error("issue stayed high for more than one cycle");

    // everything quiet right after a reset cycle
    resetQuietChk: assert property (@(posedge clk)
        reset |=> !(awready || wready || arready || bvalid || rvalid || issue))
        else $error("handshake output high in the cycle after reset");

endmodule

bind aluCoprocTop aluCoprocAssert aluCoprocAssertInst (
    .clk     (clk),
    .reset   (reset),
    .awready (awready),
    .wready  (wready),
    .arready (arready),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .rresp   (rresp),
    .issue   (issue)
);

//--- testbench/aluCoprocTb.sv
// testbench with clock, reset, axi tasks, lfsr stimulus, reference model and per-test report
`timescale 1ns/1ns
`include "alu_cfg.svh"

module aluCoprocTb import aluPkg::*; ();

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 16;
    localparam int DRIVE_DELAY    = 5;
    localparam int HANDSHAKE_WAIT = 20;
    // upper bound on transactions over all tests, and cycles of the slowest one
    localparam int TXN_BUDGET     = 800;
    localparam int TXN_MAX_CYCLES = 16;
    localparam int WATCHDOG_NS    = (RESET_CYCLES + TXN_BUDGET * TXN_MAX_CYCLES) * CLK_PERIOD;

    localparam logic [1:0] OKAY   = 2'b00;
    localparam logic [1:0] SLVERR = 2'b10;

    typedef logic [`AXI_ADDR_W-1:0] addr_t;

    logic        clk;
    logic        reset;
    word_t       inPort;
    logic        awvalid;
    logic        awready;
    addr_t       awaddr;
    logic        wvalid;
    logic        wready;
    logic [31:0] wdata;
    logic        bvalid;
    logic        bready;
    logic [1:0]  bresp;
    logic        arvalid;
    logic        arready;
    addr_t       araddr;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    logic [1:0]  rresp;

    // shadow state of the reference model
    word_t       shadow [`REG_COUNT];
    ccr_t        shadowCcr;
    logic [15:0] expCount;
    logic [31:0] lastInstr;

    logic [31:0] lfsrState;
    int          checks;
    int          errors;
    int          testsRun;
    int          testsFailed;
    int          testErrStart;

    aluCoprocTop aluCoprocTop_inst (
        .clk     (clk),
        .reset   (reset),
        .inPort  (inPort),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            clk = ~clk;
        end
    end

    // ends a run that stopped making progress
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("test failed");
        $finish;
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] lfsrBits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            val       = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic word_t randWord();
        return word_t'(lfsrBits(16));
    endfunction

    function automatic regIdx_t randReg();
        return regIdx_t'(lfsrBits(3));
    endfunction

    // ready delay of 0 to 3 cycles
    function automatic int randHold();
        return int'(lfsrBits(2));
    endfunction

    function automatic logic [31:0] encode(input logic [3:0] opc, input regIdx_t rd,
                                           input regIdx_t rs, input word_t imm);
        // low six bits are ignored by the core, so fill them with noise
        return {imm, opc, rd, rs, 6'(lfsrBits(6))};
    endfunction

    function automatic aluOp_e arithOp(input int k);
        case (k)
            0: return ADD;
            1: return SUB;
            2: return INC;
            3: return DEC;
            4: return NOT;
            5: return AND;
            default: return OR;
        endcase
    endfunction

    function automatic addr_t regAddr(input int i);
        return `ADDR_REGBASE + addr_t'(4 * i);
    endfunction

    // expected STATUS word from the shadow flags and count
    function automatic logic [31:0] statusWord();
        return {expCount, 13'h0, shadowCcr};
    endfunction

    // reference model, one issued instruction
    task automatic modelStep(input logic [31:0] word);
        logic [3:0]  opc;
        regIdx_t     rd;
        regIdx_t     rs;
        word_t       a;
        word_t       b;
        word_t       res;
        logic [16:0] wide;
        logic        carry;
        opc   = word[15:12];
        rd    = word[11:9];
        rs    = word[8:6];
        a     = shadow[rs];
        b     = shadow[rd];
        carry = 1'b0;
        res   = '0;
        case (opc)
            ADD: begin
                wide  = {1'b0, a} + {1'b0, b};
                res   = wide[15:0];
                carry = wide[16];
            end
            NOT: res = ~b;
            INC: res = b + 16'd1;
            DEC: res = b - 16'd1;
            SUB: res = b - a;
            AND: res = a & b;
            OR:  res = a | b;
            // any amount past 15 empties the word
            SHL: res = (a > 16'd15) ? 16'h0 : b << a[3:0];
            SHR: res = (a > 16'd15) ? 16'h0 : b >> a[3:0];
            IN:  res = inPort;
            LDM: res = word[31:16];
            // nop and codes 12 to 15
            default: return;
        endcase
        shadow[rd] = res;
        shadowCcr  = {carry, res[15], (res == 16'h0)};
        expCount   = expCount + 16'd1;
    endtask

    function automatic logic handshakeSig(input int sel);
        case (sel)
            0: return awready;
            1: return bvalid;
            2: return arready;
            default: return rvalid;
        endcase
    endfunction

    // polls at falling edges, where outputs are settled
    task automatic awaitHigh(input int sel, input string what, output logic ok);
        int waited;
        waited = 0;
        ok     = 1'b1;
        @(negedge clk);
        while (!handshakeSig(sel)) begin
            waited++;
            if (waited > HANDSHAKE_WAIT) begin
                errors++;
                ok = 1'b0;
                $display("%s did not arrive within %0d cycles", what, HANDSHAKE_WAIT);
                return;
            end
            @(negedge clk);
        end
    endtask

    task automatic axiWrite(input addr_t addr, input logic [31:0] data, input int hold,
                            output logic [1:0] resp);
        logic ok;
        // 2'b11 never comes back from this slave
        resp = 2'b11;
        @(posedge clk);
        #DRIVE_DELAY;
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        awaitHigh(0, "write accept", ok);
        if (ok) begin
            // wready pairs with awready in the accept cycle
            checkVal("wready", 32'(wready), 32'h1);
            // accept edge, bvalid rises with it
            @(posedge clk);
            #DRIVE_DELAY;
            awvalid = 1'b0;
            wvalid  = 1'b0;
            repeat (hold) begin
                @(posedge clk);
                #DRIVE_DELAY;
            end
            bready = 1'b1;
            awaitHigh(1, "write response", ok);
            resp = bresp;
            @(posedge clk);
            #DRIVE_DELAY;
            bready = 1'b0;
        end else begin
            awvalid = 1'b0;
            wvalid  = 1'b0;
        end
    endtask

    task automatic axiRead(input addr_t addr, input int hold, output logic [31:0] data,
                           output logic [1:0] resp);
        logic ok;
        data = '0;
        resp = 2'b11;
        @(posedge clk);
        #DRIVE_DELAY;
        arvalid = 1'b1;
        araddr  = addr;
        awaitHigh(2, "read accept", ok);
        if (ok) begin
            @(posedge clk);
            #DRIVE_DELAY;
            arvalid = 1'b0;
            // rvalid is up, response must sit still while rready is low
            repeat (hold) begin
                @(posedge clk);
                #DRIVE_DELAY;
            end
            rready = 1'b1;
            awaitHigh(3, "read data", ok);
            data = rdata;
            resp = rresp;
            @(posedge clk);
            #DRIVE_DELAY;
            rready = 1'b0;
        end else begin
            arvalid = 1'b0;
        end
    endtask

    task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic expectRead(input addr_t addr, input logic [31:0] exp,
                              input logic [1:0] expResp, input int hold, input string name);
        logic [31:0] data;
        logic [1:0]  resp;
        axiRead(addr, hold, data, resp);
        checkVal({"rresp of ", name}, 32'(resp), 32'(expResp));
        // data of an error response carries no meaning
        if (expResp == OKAY) begin
            checkVal({"rdata of ", name}, data, exp);
        end
    endtask

    task automatic expectWrite(input addr_t addr, input logic [31:0] data,
                               input logic [1:0] expResp, input string name);
        logic [1:0] resp;
        axiWrite(addr, data, 8, resp);
        checkVal({"bresp of ", name}, 32'(resp), 32'(expResp));
    endtask

    task automatic checkStatus();
        expectRead(`ADDR_STATUS, statusWord(), OKAY, randHold(), "STATUS");
    endtask

    task automatic checkReg(input int i);
        expectRead(regAddr(i), 32'(shadow[i]), OKAY, randHold(), $sformatf("r%0d", i));
    endtask

    task automatic checkAllRegs();
        for (int i = 0; i < `REG_COUNT; i++) begin
            checkReg(i);
        end
    endtask

    // issue one instruction, then compare its target register and STATUS
    task automatic runInstr(input logic [31:0] word);
        logic [1:0] resp;
        axiWrite(`ADDR_INSTR, word, randHold(), resp);
        checkVal("bresp of INSTR", 32'(resp), 32'(OKAY));
        modelStep(word);
        lastInstr = word;
        checkReg(int'(word[11:9]));
        checkStatus();
    endtask

    task automatic finishTest(input string name);
        int found;
        found = errors - testErrStart;
        testsRun++;
        if (found == 0) begin
            $display("%s: ok, %0d checks so far", name, checks);
        end else begin
            testsFailed++;
            $display("%s: FAILED with %0d errors", name, found);
        end
        testErrStart = errors;
    endtask

    task automatic testReset();
        expectRead(`ADDR_INSTR, 32'h0, OKAY, randHold(), "INSTR");
        checkStatus();
        checkAllRegs();
    endtask

    task automatic testLdm();
        // zero and negative corners first
        runInstr(encode(LDM, 3'd0, 3'd0, 16'h0000));
        runInstr(encode(LDM, 3'd1, 3'd0, 16'h8000));
        for (int i = 0; i < `REG_COUNT; i++) begin
            runInstr(encode(LDM, regIdx_t'(i), randReg(), randWord()));
        end
        checkAllRegs();
    endtask

    task automatic testArith();
        regIdx_t rs;
        regIdx_t rd;
        aluOp_e  opc;
        // carry out of ADD with a zero sum
        runInstr(encode(LDM, 3'd1, 3'd0, 16'hffff));
        runInstr(encode(LDM, 3'd2, 3'd0, 16'h0001));
        runInstr(encode(ADD, 3'd1, 3'd2, 16'h0));
        // same register on both sides
        runInstr(encode(SUB, 3'd2, 3'd2, 16'h0));
        for (int n = 0; n < 20; n++) begin
            rs = randReg();
            rd = randReg();
            runInstr(encode(LDM, rs, 3'd0, randWord()));
            runInstr(encode(LDM, rd, 3'd0, randWord()));
            opc = arithOp(int'(lfsrBits(3)) % 7);
            runInstr(encode(opc, rd, rs, randWord()));
        end
    endtask

    task automatic testShift();
        word_t amt;
        // 0 to 16 in order, then three large random amounts
        for (int a = 0; a < 20; a++) begin
            if (a < 17) begin
                amt = word_t'(a);
            end else begin
                amt = randWord() | 16'h0010;
            end
            runInstr(encode(LDM, 3'd4, 3'd0, amt));
            runInstr(encode(LDM, 3'd3, 3'd0, randWord()));
            runInstr(encode(SHL, 3'd3, 3'd4, 16'h0));
            runInstr(encode(LDM, 3'd5, 3'd0, randWord()));
            runInstr(encode(SHR, 3'd5, 3'd4, 16'h0));
        end
    endtask

    task automatic testInNop();
        for (int n = 0; n < 4; n++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            inPort = randWord();
            runInstr(encode(IN, randReg(), randReg(), randWord()));
        end
        // codes 12 to 15, then 16 wraps to opcode 0
        for (int c = 12; c <= 16; c++) begin
            runInstr(encode(4'(c % 16), randReg(), randReg(), randWord()));
        end
        checkAllRegs();
    endtask

    task automatic testErrors();
        logic [31:0] probe;
        // would overwrite r7 if any of these writes got through
        probe = encode(LDM, 3'd7, 3'd0, ~shadow[7]);
        expectWrite(`ADDR_STATUS, probe, SLVERR, "STATUS write");
        expectWrite(regAddr(0), probe, SLVERR, "r0 write");
        expectWrite(regAddr(7), probe, SLVERR, "r7 write");
        expectWrite(6'h08, probe, SLVERR, "write to 0x08");
        expectWrite(6'h1c, probe, SLVERR, "write to 0x1c");
        expectRead(6'h08, 32'h0, SLVERR, 10, "read of 0x08");
        expectRead(6'h1c, 32'h0, SLVERR, 10, "read of 0x1c");
        // misaligned inside the register window
        expectRead(6'h22, 32'h0, SLVERR, 10, "read of 0x22");
        expectRead(`ADDR_INSTR, lastInstr, OKAY, 12, "INSTR");
        checkStatus();
        checkAllRegs();
    endtask

    initial begin
        reset        = 1'b1;
        inPort       = '0;
        awvalid      = 1'b0;
        awaddr       = '0;
        wvalid       = 1'b0;
        wdata        = '0;
        bready       = 1'b0;
        arvalid      = 1'b0;
        araddr       = '0;
        rready       = 1'b0;
        lfsrState    = 32'ha79670ff;
        checks       = 0;
        errors       = 0;
        testsRun     = 0;
        testsFailed  = 0;
        testErrStart = 0;
        shadowCcr    = '0;
        expCount     = '0;
        lastInstr    = '0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            shadow[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        testReset();
        finishTest("reset");
        testLdm();
        finishTest("ldm");
        testArith();
        finishTest("arith");
        testShift();
        finishTest("shift");
        testInNop();
        finishTest("in/nop");
        testErrors();
        finishTest("errors");

        $display("summary: %0d tests, %0d failing, %0d checks, %0d errors",
                 testsRun, testsFailed, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+include
hw/aluPkg.sv
hw/alu.sv
hw/regFile.sv
hw/execCore.sv
hw/hostRegs.sv
hw/aluCoprocTop.sv
testbench/aluCoproc_assert.sv
testbench/aluCoprocTb.sv

//--- run.sh
#!/usr/bin/env bash
# build with verilator, run, and look for the pass line in the simulation output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module aluCoprocTb -f list.f --Mdir obj_dir -o aluCoprocSim \
    && ./obj_dir/aluCoprocSim | tee /dev/stderr | grep -qx "test passed" \
    && echo "run.sh: simulation ok" \
    || { echo "run.sh: simulation FAILED"; exit 1; }
